/* hw/axi_pkg.sv */
/*
 * bus protocol types shared by all stages
 *   axi_resp_e  response code on the r and b channels
 *   txn_kind_e  kind of transaction held in a stage
 */
`default_nettype none

package axi_pkg;

	// two-bit response code as on the wire
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10, // device error
		DECERR = 2'b11  // no device at that address
	} axi_resp_e;

	// read or write, latched when a stage takes a request
	typedef enum logic {
		READ  = 1'b0,
		WRITE = 1'b1
	} txn_kind_e;

endpackage

`default_nettype wire

/* hw/soc_map_pkg.sv */
/*
 * address map of the memory subsystem
 *   sram window base, serial port register address
 *   target_e  destination picked by the crossbar decode
 */
`default_nettype none

package soc_map_pkg;

	localparam logic [31:0] SRAM_BASE   = 32'h8000_0000; // window length set by SRAM_WORDS
	localparam logic [31:0] SERIAL_PORT = 32'hA000_03F8; // uart transmit register, one word

	// crossbar destination
	typedef enum logic [1:0] {
		TGT_SRAM = 2'd0,
		TGT_UART = 2'd1,
		TGT_NONE = 2'd2  // unmapped, answered with DECERR
	} target_e;

endpackage

`default_nettype wire

/* hw/axi_lite_if.sv */
/*
 * five-channel AXI-lite bundle
 *   ar, r, aw, w, b channels with valid/ready
 *   manager and subordinate modports
 */
`default_nettype none

interface axi_lite_if import axi_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) ();
	logic [ADDR_W-1:0]   ar_addr; // read address
	logic                ar_valid;
	logic                ar_ready;
	logic [DATA_W-1:0]   r_data;  // read data
	axi_resp_e           r_resp;
	logic                r_valid;
	logic                r_ready;
	logic [ADDR_W-1:0]   aw_addr; // write address
	logic                aw_valid;
	logic                aw_ready;
	logic [DATA_W-1:0]   w_data;  // write data
	logic [DATA_W/8-1:0] w_strb;  // one bit per byte lane
	logic                w_valid;
	logic                w_ready;
	axi_resp_e           b_resp;  // write response
	logic                b_valid;
	logic                b_ready;

	modport manager (
		output ar_addr, ar_valid, r_ready, aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
		input  ar_ready, r_data, r_resp, r_valid, aw_ready, w_ready, b_resp, b_valid
	);

	modport subordinate (
		input  ar_addr, ar_valid, r_ready, aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
		output ar_ready, r_data, r_resp, r_valid, aw_ready, w_ready, b_resp, b_valid
	);

endinterface

`default_nettype wire

/* hw/axi_arbiter.sv */
/*
 * request arbiter between instruction fetch and data load/store
 *   priority data write, data read, instruction read
 *   one open transaction, registered onto the shared bus
 *   response returned only to the owning port
 */
`default_nettype none

module axi_arbiter import axi_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  wire logic                clk,
	input  wire logic                rst,
	// instruction port, read only
	input  wire logic [ADDR_W-1:0]   inst_ar_addr_i,
	input  wire logic                inst_ar_valid_i,
	output logic                     inst_ar_ready_o,
	output logic [DATA_W-1:0]        inst_r_data_o,
	output axi_resp_e                inst_r_resp_o,
	output logic                     inst_r_valid_o,
	input  wire logic                inst_r_ready_i,
	// data port, read side
	input  wire logic [ADDR_W-1:0]   data_ar_addr_i,
	input  wire logic                data_ar_valid_i,
	output logic                     data_ar_ready_o,
	output logic [DATA_W-1:0]        data_r_data_o,
	output axi_resp_e                data_r_resp_o,
	output logic                     data_r_valid_o,
	input  wire logic                data_r_ready_i,
	// data port, write side
	input  wire logic [ADDR_W-1:0]   data_aw_addr_i,
	input  wire logic                data_aw_valid_i,
	output logic                     data_aw_ready_o,
	input  wire logic [DATA_W-1:0]   data_w_data_i,
	input  wire logic [DATA_W/8-1:0] data_w_strb_i,
	input  wire logic                data_w_valid_i,
	output logic                     data_w_ready_o,
	output axi_resp_e                data_b_resp_o,
	output logic                     data_b_valid_o,
	input  wire logic                data_b_ready_i,
	axi_lite_if.manager              bus_o
);
	typedef enum logic [1:0] {ARB_IDLE, ARB_ISSUE, ARB_WAIT, ARB_RESP} arb_state_e;

	arb_state_e          state_q;
	logic                owner_data_q; // set: data port owns the transaction
	txn_kind_e           kind_q;
	logic [ADDR_W-1:0]   addr_q;
	logic [DATA_W-1:0]   wdata_q;
	logic [DATA_W/8-1:0] strb_q;
	logic [DATA_W-1:0]   rdata_q;
	axi_resp_e           resp_q;
	logic                grant_wr;
	logic                grant_dr;
	logic                grant_ir;
	logic                accept;
	logic                issue_done;
	logic                resp_in;
	logic                resp_done;

	// combinational grant, only while idle
	assign grant_wr = (state_q == ARB_IDLE) && data_aw_valid_i && data_w_valid_i;
	assign grant_dr = (state_q == ARB_IDLE) && !grant_wr && data_ar_valid_i;
	assign grant_ir = (state_q == ARB_IDLE) && !grant_wr && !data_ar_valid_i && inst_ar_valid_i;
	assign accept   = grant_wr || grant_dr || grant_ir;

	assign data_aw_ready_o = grant_wr; // aw and w taken together
	assign data_w_ready_o  = grant_wr;
	assign data_ar_ready_o = grant_dr;
	assign inst_ar_ready_o = grant_ir;

	// registered request onto the shared bus
	assign bus_o.ar_addr  = addr_q;
	assign bus_o.aw_addr  = addr_q;
	assign bus_o.w_data   = wdata_q;
	assign bus_o.w_strb   = strb_q;
	assign bus_o.ar_valid = (state_q == ARB_ISSUE) && (kind_q == READ);
	assign bus_o.aw_valid = (state_q == ARB_ISSUE) && (kind_q == WRITE);
	assign bus_o.w_valid  = bus_o.aw_valid;
	assign bus_o.r_ready  = (state_q == ARB_WAIT);
	assign bus_o.b_ready  = (state_q == ARB_WAIT);

	assign issue_done = (bus_o.ar_valid && bus_o.ar_ready) ||
		(bus_o.aw_valid && bus_o.aw_ready && bus_o.w_ready);
	assign resp_in = (state_q == ARB_WAIT) &&
		((kind_q == READ) ? bus_o.r_valid : bus_o.b_valid);

	// response goes to the owner only
	assign inst_r_valid_o = (state_q == ARB_RESP) && !owner_data_q; // inst never writes
	assign data_r_valid_o = (state_q == ARB_RESP) && owner_data_q && (kind_q == READ);
	assign data_b_valid_o = (state_q == ARB_RESP) && (kind_q == WRITE);
	assign inst_r_data_o  = rdata_q;
	assign inst_r_resp_o  = resp_q;
	assign data_r_data_o  = rdata_q;
	assign data_r_resp_o  = resp_q;
	assign data_b_resp_o  = resp_q;

	assign resp_done = (inst_r_valid_o && inst_r_ready_i) ||
		(data_r_valid_o && data_r_ready_i) || (data_b_valid_o && data_b_ready_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= ARB_IDLE;
			owner_data_q <= 1'b0;
			kind_q       <= READ;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (accept) begin
						state_q      <= ARB_ISSUE;
						owner_data_q <= grant_wr || grant_dr;
						if (grant_wr)
							kind_q <= WRITE;
						else
							kind_q <= READ;
					end
				end
				ARB_ISSUE: if (issue_done) state_q <= ARB_WAIT;
				ARB_WAIT:  if (resp_in) state_q <= ARB_RESP;
				ARB_RESP:  if (resp_done) state_q <= ARB_IDLE; // back to idle on handoff
				default:   state_q <= ARB_IDLE;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (accept) begin
			if (grant_wr)
				addr_q <= data_aw_addr_i;
			else if (grant_dr)
				addr_q <= data_ar_addr_i;
			else
				addr_q <= inst_ar_addr_i;
			wdata_q <= data_w_data_i;
			strb_q  <= grant_wr ? data_w_strb_i : '0;
		end
		if (resp_in) begin
			if (kind_q == READ) begin
				rdata_q <= bus_o.r_data;
				resp_q  <= bus_o.r_resp;
			end else begin
				rdata_q <= '0;
				resp_q  <= bus_o.b_resp;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/axi_xbar.sv */
/*
 * address decode crossbar
 *   latches one request, routes it to sram or uart
 *   unmapped addresses answered here with DECERR
 */
`default_nettype none

module axi_xbar import axi_pkg::*, soc_map_pkg::*; #(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32,
	parameter int SRAM_WORDS = 256
) (
	input wire logic        clk,
	input wire logic        rst,
	axi_lite_if.subordinate up_i,
	axi_lite_if.manager     sram_o,
	axi_lite_if.manager     uart_o
);
	typedef enum logic [1:0] {XB_IDLE, XB_ISSUE, XB_WAIT, XB_RESP} xb_state_e;

	xb_state_e           state_q;
	txn_kind_e           kind_q;
	target_e             tgt_q;
	target_e             dec_tgt;
	logic [ADDR_W-1:0]   addr_q;
	logic [DATA_W-1:0]   wdata_q;
	logic [DATA_W/8-1:0] strb_q;
	logic [DATA_W-1:0]   rdata_q;
	axi_resp_e           resp_q;
	logic                wr_req;
	logic                acc_wr;
	logic                acc_rd;
	logic                sel_sram;
	logic                issue_done;
	logic                resp_in;

	function automatic target_e decode(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] offs;
		offs = addr - ADDR_W'(SRAM_BASE); // wraps below base, so one compare
		if (offs < ADDR_W'(SRAM_WORDS * 4))
			return TGT_SRAM;
		if (addr == ADDR_W'(SERIAL_PORT))
			return TGT_UART;
		return TGT_NONE;
	endfunction

	// upstream accept, write needs aw and w together
	assign wr_req        = up_i.aw_valid && up_i.w_valid;
	assign up_i.aw_ready = (state_q == XB_IDLE) && wr_req;
	assign up_i.w_ready  = up_i.aw_ready;
	assign up_i.ar_ready = (state_q == XB_IDLE) && !wr_req;
	assign acc_wr        = up_i.aw_ready;
	assign acc_rd        = up_i.ar_ready && up_i.ar_valid;
	assign dec_tgt       = decode(acc_wr ? up_i.aw_addr : up_i.ar_addr);

	assign up_i.r_data  = rdata_q;
	assign up_i.r_resp  = resp_q;
	assign up_i.b_resp  = resp_q;
	assign up_i.r_valid = (state_q == XB_RESP) && (kind_q == READ);
	assign up_i.b_valid = (state_q == XB_RESP) && (kind_q == WRITE);

	assign sel_sram = (tgt_q == TGT_SRAM);

	// replay on both buses, valids gated by target
	assign sram_o.ar_addr  = addr_q;
	assign sram_o.aw_addr  = addr_q;
	assign sram_o.w_data   = wdata_q;
	assign sram_o.w_strb   = strb_q;
	assign sram_o.ar_valid = (state_q == XB_ISSUE) && sel_sram && (kind_q == READ);
	assign sram_o.aw_valid = (state_q == XB_ISSUE) && sel_sram && (kind_q == WRITE);
	assign sram_o.w_valid  = sram_o.aw_valid;
	assign sram_o.r_ready  = (state_q == XB_WAIT) && sel_sram;
	assign sram_o.b_ready  = sram_o.r_ready;

	assign uart_o.ar_addr  = addr_q;
	assign uart_o.aw_addr  = addr_q;
	assign uart_o.w_data   = wdata_q;
	assign uart_o.w_strb   = strb_q;
	assign uart_o.ar_valid = (state_q == XB_ISSUE) && !sel_sram && (kind_q == READ);
	assign uart_o.aw_valid = (state_q == XB_ISSUE) && !sel_sram && (kind_q == WRITE);
	assign uart_o.w_valid  = uart_o.aw_valid;
	assign uart_o.r_ready  = (state_q == XB_WAIT) && !sel_sram;
	assign uart_o.b_ready  = uart_o.r_ready;

	assign issue_done = (sram_o.ar_valid && sram_o.ar_ready) ||
		(sram_o.aw_valid && sram_o.aw_ready && sram_o.w_ready) ||
		(uart_o.ar_valid && uart_o.ar_ready) ||
		(uart_o.aw_valid && uart_o.aw_ready && uart_o.w_ready);
	assign resp_in = (sram_o.r_ready && (sram_o.r_valid || sram_o.b_valid)) ||
		(uart_o.r_ready && (uart_o.r_valid || uart_o.b_valid));

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= XB_IDLE;
			kind_q  <= READ;
			tgt_q   <= TGT_NONE;
		end else begin
			case (state_q)
				XB_IDLE: begin
					if (acc_wr || acc_rd) begin
						tgt_q   <= dec_tgt;
						kind_q  <= acc_wr ? WRITE : READ;
						state_q <= (dec_tgt == TGT_NONE) ? XB_RESP : XB_ISSUE; // decerr next cycle
					end
				end
				XB_ISSUE: if (issue_done) state_q <= XB_WAIT;
				XB_WAIT:  if (resp_in) state_q <= XB_RESP;
				XB_RESP:  if ((up_i.r_valid && up_i.r_ready) || (up_i.b_valid && up_i.b_ready))
					state_q <= XB_IDLE;
				default:  state_q <= XB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (acc_wr || acc_rd) begin
			addr_q  <= acc_wr ? up_i.aw_addr : up_i.ar_addr;
			wdata_q <= up_i.w_data;
			strb_q  <= acc_wr ? up_i.w_strb : '0;
			rdata_q <= '0;     // stands for an unmapped read
			resp_q  <= DECERR; // replaced when a device answers
		end else if (resp_in) begin
			if (kind_q == READ) begin
				rdata_q <= sel_sram ? sram_o.r_data : uart_o.r_data;
				resp_q  <= sel_sram ? sram_o.r_resp : uart_o.r_resp;
			end else begin
				resp_q <= sel_sram ? sram_o.b_resp : uart_o.b_resp;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/axi_sram.sv */
/*
 * word-wide sram subordinate
 *   byte-strobed writes, registered read
 *   response one cycle after acceptance, always OKAY
 */
`default_nettype none

module axi_sram import axi_pkg::*, soc_map_pkg::*; #(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32,
	parameter int SRAM_WORDS = 256
) (
	input wire logic        clk,
	input wire logic        rst,
	axi_lite_if.subordinate bus_i
);
	localparam int IDX_W = $clog2(SRAM_WORDS);

	logic [DATA_W-1:0] mem [SRAM_WORDS]; // contents undefined after reset
	logic [DATA_W-1:0] rdata_q;
	logic              busy_q;           // response pending
	txn_kind_e         kind_q;
	logic              wr_req;
	logic              acc_wr;
	logic              acc_rd;
	logic              done;

	// word index from the offset into the window
	function automatic logic [IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] offs;
		offs = addr - ADDR_W'(SRAM_BASE);
		return offs[IDX_W+1:2];
	endfunction

	assign wr_req         = bus_i.aw_valid && bus_i.w_valid;
	assign bus_i.aw_ready = !busy_q && wr_req;
	assign bus_i.w_ready  = bus_i.aw_ready;
	assign bus_i.ar_ready = !busy_q && !wr_req;
	assign acc_wr         = bus_i.aw_ready;
	assign acc_rd         = bus_i.ar_ready && bus_i.ar_valid;

	assign bus_i.r_data  = rdata_q;
	assign bus_i.r_resp  = OKAY;
	assign bus_i.b_resp  = OKAY;
	assign bus_i.r_valid = busy_q && (kind_q == READ);
	assign bus_i.b_valid = busy_q && (kind_q == WRITE);
	assign done = (bus_i.r_valid && bus_i.r_ready) || (bus_i.b_valid && bus_i.b_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			kind_q <= READ;
		end else if (acc_wr || acc_rd) begin
			busy_q <= 1'b1;
			kind_q <= acc_wr ? WRITE : READ;
		end else if (done) begin
			busy_q <= 1'b0;
		end
	end

	// storage, only strobed lanes change
	always_ff @(posedge clk) begin
		if (acc_wr) begin
			for (int b = 0; b < DATA_W / 8; b++) begin
				if (bus_i.w_strb[b])
					mem[word_idx(bus_i.aw_addr)][b*8 +: 8] <= bus_i.w_data[b*8 +: 8];
			end
		end
		if (acc_rd)
			rdata_q <= mem[word_idx(bus_i.ar_addr)];
	end

endmodule

`default_nettype wire

/* hw/axi_uart_tx.sv */
/*
 * serial port transmit register
 *   lane 0 byte out with a one-cycle strobe
 *   reads give zero, every response OKAY
 */
`default_nettype none

module axi_uart_tx import axi_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  wire logic       clk,
	input  wire logic       rst,
	axi_lite_if.subordinate bus_i,
	output logic [7:0]      uart_data_o,
	output logic            uart_strobe_o
);
	logic       busy_q;   // response pending
	txn_kind_e  kind_q;
	logic [7:0] data_q;
	logic       strobe_q;
	logic       wr_req;
	logic       acc_wr;
	logic       acc_rd;
	logic       done;

	assign wr_req         = bus_i.aw_valid && bus_i.w_valid;
	assign bus_i.aw_ready = !busy_q && wr_req;
	assign bus_i.w_ready  = bus_i.aw_ready;
	assign bus_i.ar_ready = !busy_q && !wr_req;
	assign acc_wr         = bus_i.aw_ready;
	assign acc_rd         = bus_i.ar_ready && bus_i.ar_valid;

	assign bus_i.r_data  = {DATA_W{1'b0}}; // no receive side
	assign bus_i.r_resp  = OKAY;
	assign bus_i.b_resp  = OKAY;
	assign bus_i.r_valid = busy_q && (kind_q == READ);
	assign bus_i.b_valid = busy_q && (kind_q == WRITE);
	assign done = (bus_i.r_valid && bus_i.r_ready) || (bus_i.b_valid && bus_i.b_ready);

	assign uart_data_o   = data_q;
	assign uart_strobe_o = strobe_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q   <= 1'b0;
			kind_q   <= READ;
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= acc_wr && bus_i.w_strb[0]; // pulse the cycle after accept
			if (acc_wr || acc_rd) begin
				busy_q <= 1'b1;
				kind_q <= acc_wr ? WRITE : READ;
			end else if (done) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acc_wr && bus_i.w_strb[0])
			data_q <= bus_i.w_data[7:0];
	end

endmodule

`default_nettype wire

/* hw/soc_mem_top.sv */
/*
 * memory subsystem top level
 *   arbiter, crossbar, sram and uart
 *   bus widths and sram depth set here
 */
`default_nettype none

module soc_mem_top import axi_pkg::*; #(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32,
	parameter int SRAM_WORDS = 256
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic [ADDR_W-1:0]   inst_ar_addr_i,
	input  wire logic                inst_ar_valid_i,
	output logic                     inst_ar_ready_o,
	output logic [DATA_W-1:0]        inst_r_data_o,
	output axi_resp_e                inst_r_resp_o,
	output logic                     inst_r_valid_o,
	input  wire logic                inst_r_ready_i,
	input  wire logic [ADDR_W-1:0]   data_ar_addr_i,
	input  wire logic                data_ar_valid_i,
	output logic                     data_ar_ready_o,
	output logic [DATA_W-1:0]        data_r_data_o,
	output axi_resp_e                data_r_resp_o,
	output logic                     data_r_valid_o,
	input  wire logic                data_r_ready_i,
	input  wire logic [ADDR_W-1:0]   data_aw_addr_i,
	input  wire logic                data_aw_valid_i,
	output logic                     data_aw_ready_o,
	input  wire logic [DATA_W-1:0]   data_w_data_i,
	input  wire logic [DATA_W/8-1:0] data_w_strb_i,
	input  wire logic                data_w_valid_i,
	output logic                     data_w_ready_o,
	output axi_resp_e                data_b_resp_o,
	output logic                     data_b_valid_o,
	input  wire logic                data_b_ready_i,
	output logic [7:0]               uart_data_o,
	output logic                     uart_strobe_o
);
	axi_lite_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) arb_bus ();  // arbiter to crossbar
	axi_lite_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) sram_bus (); // crossbar to sram
	axi_lite_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uart_bus (); // crossbar to uart

	axi_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_arb (
		.bus_o (arb_bus.manager),
		.*
	);

	axi_xbar #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SRAM_WORDS(SRAM_WORDS)) u_xbar (
		.clk    (clk),
		.rst    (rst),
		.up_i   (arb_bus.subordinate),
		.sram_o (sram_bus.manager),
		.uart_o (uart_bus.manager)
	);

	axi_sram #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SRAM_WORDS(SRAM_WORDS)) u_sram (
		.clk   (clk),
		.rst   (rst),
		.bus_i (sram_bus.subordinate)
	);

	axi_uart_tx #(.DATA_W(DATA_W)) u_uart (
		.clk           (clk),
		.rst           (rst),
		.bus_i         (uart_bus.subordinate),
		.uart_data_o   (uart_data_o),
		.uart_strobe_o (uart_strobe_o)
	);

endmodule

`default_nettype wire

/* test/axi_checker.sv */
/*
 * concurrent checks on the arbiter ports
 *   one request grant per cycle, one read response at a time
 *   responses held until taken, no grant while a response is offered
 *   bound into every axi_arbiter
 */
`default_nettype none

module axi_checker #(
	parameter int DATA_W = 32
) (
	input wire logic              clk,
	input wire logic              rst,
	input wire logic              inst_ar_ready_o,
	input wire logic              data_ar_ready_o,
	input wire logic              data_aw_ready_o,
	input wire logic [DATA_W-1:0] inst_r_data_o,
	input wire logic [1:0]        inst_r_resp_o,
	input wire logic              inst_r_valid_o,
	input wire logic              inst_r_ready_i,
	input wire logic [DATA_W-1:0] data_r_data_o,
	input wire logic [1:0]        data_r_resp_o,
	input wire logic              data_r_valid_o,
	input wire logic              data_r_ready_i,
	input wire logic [1:0]        data_b_resp_o,
	input wire logic              data_b_valid_o,
	input wire logic              data_b_ready_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// grant goes to one port at most
	assert property (@(posedge clk) disable iff (rst)
		$onehot0({inst_ar_ready_o, data_ar_ready_o, data_aw_ready_o}))
		else $error("more than one request port granted in one cycle");

	assert property (@(posedge clk) disable iff (rst)
		!(inst_r_valid_o && data_r_valid_o))
		else $error("read response offered on both ports");

	// offered response stays put until taken
	assert property (@(posedge clk) disable iff (rst)
		inst_r_valid_o && !inst_r_ready_i |=>
		inst_r_valid_o && $stable(inst_r_data_o) && $stable(inst_r_resp_o))
		else $error("instruction read response changed before it was taken");

	assert property (@(posedge clk) disable iff (rst)
		data_r_valid_o && !data_r_ready_i |=>
		data_r_valid_o && $stable(data_r_data_o) && $stable(data_r_resp_o))
		else $error("data read response changed before it was taken");

	assert property (@(posedge clk) disable iff (rst)
		data_b_valid_o && !data_b_ready_i |=> data_b_valid_o && $stable(data_b_resp_o))
		else $error("write response changed before it was taken");

	// transaction still open, no new grant
	assert property (@(posedge clk) disable iff (rst)
		(inst_r_valid_o || data_r_valid_o || data_b_valid_o) |->
		!(inst_ar_ready_o || data_ar_ready_o || data_aw_ready_o))
		else $error("request granted while a response is pending");

endmodule

bind axi_arbiter axi_checker #(.DATA_W(DATA_W)) chk0 (
	.clk             (clk),
	.rst             (rst),
	.inst_ar_ready_o (inst_ar_ready_o),
	.data_ar_ready_o (data_ar_ready_o),
	.data_aw_ready_o (data_aw_ready_o),
	.inst_r_data_o   (inst_r_data_o),
	.inst_r_resp_o   (inst_r_resp_o),
	.inst_r_valid_o  (inst_r_valid_o),
	.inst_r_ready_i  (inst_r_ready_i),
	.data_r_data_o   (data_r_data_o),
	.data_r_resp_o   (data_r_resp_o),
	.data_r_valid_o  (data_r_valid_o),
	.data_r_ready_i  (data_r_ready_i),
	.data_b_resp_o   (data_b_resp_o),
	.data_b_valid_o  (data_b_valid_o),
	.data_b_ready_i  (data_b_ready_i)
);

`default_nettype wire

/* test/tb_soc_mem.sv */
/*
 * testbench for the memory subsystem
 *   clock, reset, lcg stimulus on instruction and data ports
 *   reference memory model and expected response queue
 *   compare process with random ready stalls, uart byte check
 *   timeout and closing summary
 */
`default_nettype none

module tb_soc_mem import axi_pkg::*, soc_map_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SRAM_WORDS = 256; // same as the dut default
	localparam int RST_CYCLES = 10;
	localparam int N_RAND     = 200; // rounds of write, read back, fetch
	localparam int N_PRIO     = 8;   // rounds of three competing requests
	localparam int TOTAL_TXN  = SRAM_WORDS + 3 * N_RAND + 3 * N_PRIO;
	localparam int MAX_CYCLES = 200 * TOTAL_TXN + RST_CYCLES;
	localparam logic [1:0] CH_IR = 2'd0; // instruction read
	localparam logic [1:0] CH_DR = 2'd1; // data read
	localparam logic [1:0] CH_DW = 2'd2; // data write

	logic        clk;
	logic        rst;
	logic [31:0] inst_ar_addr_i, data_ar_addr_i, data_aw_addr_i, data_w_data_i;
	logic [3:0]  data_w_strb_i;
	logic        inst_ar_valid_i, data_ar_valid_i, data_aw_valid_i, data_w_valid_i;
	logic        inst_r_ready_i, data_r_ready_i, data_b_ready_i;
	logic        inst_ar_ready_o, data_ar_ready_o, data_aw_ready_o, data_w_ready_o;
	logic [31:0] inst_r_data_o, data_r_data_o;
	axi_resp_e   inst_r_resp_o, data_r_resp_o, data_b_resp_o;
	logic        inst_r_valid_o, data_r_valid_o, data_b_valid_o;
	logic [7:0]  uart_data_o;
	logic        uart_strobe_o;

	logic [31:0] model_mem [SRAM_WORDS]; // reference copy of the sram
	logic [35:0] exp_q[$];               // {channel, resp, data} in acceptance order
	logic [7:0]  uart_q[$];              // bytes still due on the uart
	logic [1:0]  done_order[$];          // channels in completion order
	logic [31:0] stim_seed = 32'd42;
	logic [31:0] rdy_seed [3];           // one stream per response channel
	logic        pend [3];               // offered last cycle and not taken
	logic [31:0] last_data [3];
	logic [1:0]  last_resp [3];
	int          errors = 0;
	int          issued = 0;
	int          cycles = 0;

	soc_mem_top dut0 (.*);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_seed = lcg(stim_seed);
		return stim_seed;
	endfunction

	function automatic logic [31:0] sram_addr(input logic [31:0] r);
		return SRAM_BASE + (((r >> 12) % SRAM_WORDS) << 2); // word aligned inside the window
	endfunction

	// mostly sram, some uart, some unmapped
	function automatic logic [31:0] rand_addr();
		logic [31:0] r;
		logic [31:0] s;
		r = next_rand();
		s = next_rand();
		if (r[31:29] == 3'd6)
			return SERIAL_PORT;
		if (r[31:29] != 3'd7)
			return sram_addr(s);
		case (s[31:30])
			2'd0:    return SRAM_BASE + SRAM_WORDS * 4 + {20'h0, s[11:2], 2'b00}; // past the end
			2'd1:    return SERIAL_PORT + 32'd4;
			2'd2:    return SRAM_BASE - 32'd4;
			default: return {4'h1, s[27:2], 2'b00};
		endcase
	endfunction

	// expected {channel, resp, data} and the model updates of a write
	function automatic logic [35:0] expected_resp(input logic [1:0] ch, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb);
		target_e     tgt;
		logic [31:0] offs;
		int          idx;
		logic [31:0] rdata;
		axi_resp_e   resp;
		offs = addr - SRAM_BASE;
		idx  = int'(offs >> 2);
		if (addr >= SRAM_BASE && offs < SRAM_WORDS * 4)
			tgt = TGT_SRAM;
		else if (addr == SERIAL_PORT)
			tgt = TGT_UART;
		else
			tgt = TGT_NONE;
		rdata = '0; // unmapped and uart reads give zero
		resp  = (tgt == TGT_NONE) ? DECERR : OKAY;
		if (ch == CH_DW && tgt == TGT_SRAM) begin
			for (int b = 0; b < 4; b++)
				if (strb[b])
					model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
		end else if (ch == CH_DW && tgt == TGT_UART && strb[0]) begin
			uart_q.push_back(wdata[7:0]); // lane 0 only
		end else if (ch != CH_DW && tgt == TGT_SRAM) begin
			rdata = model_mem[idx];
		end
		return {ch, resp, rdata};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic string chan_name(input logic [1:0] ch);
		case (ch)
			CH_IR:   return "inst_r";
			CH_DR:   return "data_r";
			default: return "data_b";
		endcase
	endfunction

	// one response channel per negedge with a random ready
	task automatic watch_channel(input logic [1:0] ch, input logic valid,
		input logic [31:0] data, input logic [1:0] resp, output logic ready);
		logic [35:0] e;
		if (pend[ch]) begin
			if (!valid) begin
				errors++;
				$display("%s_valid_o dropped before the response was taken at %0t",
					chan_name(ch), $time);
			end else begin
				if (ch != CH_DW)
					compare_value({chan_name(ch), "_data_o held"}, data, last_data[ch]);
				compare_value({chan_name(ch), "_resp_o held"}, 32'(resp), 32'(last_resp[ch]));
			end
		end
		rdy_seed[ch]  = lcg(rdy_seed[ch]);
		ready         = (rdy_seed[ch][31:30] != 2'b00); // stall about one cycle in four
		pend[ch]      = valid && !ready;
		last_data[ch] = data;
		last_resp[ch] = resp;
		if (valid && ready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("response on %s with no request outstanding at %0t",
					chan_name(ch), $time);
			end else begin
				e = exp_q.pop_front();
				compare_value("response channel", 32'(ch), 32'(e[35:34]));
				compare_value({chan_name(ch), "_resp_o"}, 32'(resp), 32'(e[33:32]));
				if (ch != CH_DW)
					compare_value({chan_name(ch), "_data_o"}, data, e[31:0]);
				done_order.push_back(ch);
			end
		end
	endtask

	task automatic write_req(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb);
		@(negedge clk);
		data_aw_addr_i  = addr;
		data_w_data_i   = wdata;
		data_w_strb_i   = strb;
		data_aw_valid_i = 1'b1;
		data_w_valid_i  = 1'b1;
		#1;
		while (!data_aw_ready_o) begin
			@(negedge clk);
			#1;
		end
		compare_value("data_w_ready_o", 32'(data_w_ready_o), 32'd1); // aw and w go together
		exp_q.push_back(expected_resp(CH_DW, addr, wdata, strb)); // taken at next posedge
		issued++;
		@(negedge clk);
		data_aw_valid_i = 1'b0;
		data_w_valid_i  = 1'b0;
	endtask

	task automatic read_req(input logic [1:0] ch, input logic [31:0] addr);
		@(negedge clk);
		if (ch == CH_IR) begin
			inst_ar_addr_i  = addr;
			inst_ar_valid_i = 1'b1;
		end else begin
			data_ar_addr_i  = addr;
			data_ar_valid_i = 1'b1;
		end
		#1;
		while (!((ch == CH_IR) ? inst_ar_ready_o : data_ar_ready_o)) begin
			@(negedge clk);
			#1;
		end
		exp_q.push_back(expected_resp(ch, addr, 32'h0, 4'h0));
		issued++;
		@(negedge clk);
		if (ch == CH_IR)
			inst_ar_valid_i = 1'b0;
		else
			data_ar_valid_i = 1'b0;
	endtask

	// off the negedge so pops there are settled
	task automatic wait_drained();
		@(negedge clk);
		#2;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			#2;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles with %0d responses outstanding",
				cycles, exp_q.size());
			$display("%0d errors over %0d transactions", errors, issued);
			$display("Something failed");
			$finish;
		end
	end

	// compare process for responses and uart strobes
	always @(negedge clk) begin
		if (cycles > RST_CYCLES) begin
			watch_channel(CH_IR, inst_r_valid_o, inst_r_data_o, inst_r_resp_o, inst_r_ready_i);
			watch_channel(CH_DR, data_r_valid_o, data_r_data_o, data_r_resp_o, data_r_ready_i);
			watch_channel(CH_DW, data_b_valid_o, 32'h0, data_b_resp_o, data_b_ready_i);
			if (uart_strobe_o) begin
				if (uart_q.size() == 0) begin
					errors++;
					$display("uart strobe with byte 0x%0h that no write asked for", uart_data_o);
				end else begin
					compare_value("uart_data_o", 32'(uart_data_o), 32'(uart_q.pop_front()));
				end
			end
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0]  s;
		rst             = 1'b1;
		inst_ar_addr_i  = '0;
		inst_ar_valid_i = 1'b0;
		inst_r_ready_i  = 1'b0;
		data_ar_addr_i  = '0;
		data_ar_valid_i = 1'b0;
		data_r_ready_i  = 1'b0;
		data_aw_addr_i  = '0;
		data_aw_valid_i = 1'b0;
		data_w_data_i   = '0;
		data_w_strb_i   = '0;
		data_w_valid_i  = 1'b0;
		data_b_ready_i  = 1'b0;
		for (int i = 0; i < 3; i++) begin
			rdy_seed[i] = next_rand();
			pend[i]     = 1'b0;
		end
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// known contents first with an address-derived pattern
		for (int i = 0; i < SRAM_WORDS; i++) begin
			a = SRAM_BASE + i * 4;
			write_req(a, a ^ 32'hC3A5_96F0, 4'hF);
		end

		for (int i = 0; i < N_RAND; i++) begin
			a = rand_addr();
			d = next_rand();
			s = 4'(next_rand() >> 28); // partial strobes with some lacking lane 0
			write_req(a, d, s);
			read_req(CH_DR, a); // merged word back
			read_req(CH_IR, rand_addr());
		end
		wait_drained();

		// all three ports at once to see the grant order
		for (int i = 0; i < N_PRIO; i++) begin
			a = sram_addr(next_rand());
			d = next_rand();
			done_order.delete();
			fork
				write_req(a, d, 4'hF);
				read_req(CH_DR, a);
				read_req(CH_IR, sram_addr(d));
			join
			wait_drained();
			compare_value("completed responses", done_order.size(), 32'd3);
			if (done_order.size() == 3)
				compare_value("completion order",
					32'({done_order[0], done_order[1], done_order[2]}),
					32'({CH_DW, CH_DR, CH_IR}));
		end

		compare_value("uart bytes left", uart_q.size(), 32'd0);
		$display("%0d errors over %0d transactions", errors, issued);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/axi_pkg.sv
hw/soc_map_pkg.sv
hw/axi_lite_if.sv
hw/axi_arbiter.sv
hw/axi_xbar.sv
hw/axi_sram.sv
hw/axi_uart_tx.sv
hw/soc_mem_top.sv
test/axi_checker.sv
test/tb_soc_mem.sv
